// File: logic/exec_pkg.sv
`default_nettype none

package exec_pkg;

    // Major opcodes seen at issue
    typedef enum logic [6:0] {
        OP_ALU    = 7'b0110011,  // Register ALU, also carries M extension
        OP_ALUI   = 7'b0010011,  // Immediate ALU
        OP_BRANCH = 7'b1100011,  // Conditional branch
        OP_MULDIV = 7'b1001111   // Custom divide opcode
    } opcode_e;

    // Functional unit chosen by the decoder
    typedef enum logic [1:0] {
        UNIT_ADD,
        UNIT_MUL,
        UNIT_DIV
    } unit_e;

    typedef struct packed {
        logic       branch;  // Resolve as a branch
        logic       sub;     // Subtract or arithmetic shift
        logic       muldiv;  // M extension op
        logic       imm;     // Operand2 is an immediate
        logic [2:0] spare;   // Carried only
    } ctl_t;

    typedef struct packed {
        logic [31:0] operand1;
        logic [31:0] operand2;
        logic [2:0]  func3;
        logic [31:0] pc;
        logic [31:0] label;       // Branch offset
        ctl_t        ctl;
        logic [7:0]  rd_phy_reg;
    } uop_t;

    typedef struct packed {
        logic        valid;       // One-cycle pulse per finished op
        logic [7:0]  rd_phy_reg;
        logic [31:0] value;
        logic        taken;       // Branch outcome, low for other ops
    } result_t;

    typedef struct packed {
        logic add;
        logic mul;
        logic div;
    } station_full_t;

    // ALU func3
    localparam logic [2:0] F3_ADD    = 3'b000;  // add or sub
    localparam logic [2:0] F3_SLL    = 3'b001;
    localparam logic [2:0] F3_SLT    = 3'b010;
    localparam logic [2:0] F3_SLTU   = 3'b011;
    localparam logic [2:0] F3_XOR    = 3'b100;
    localparam logic [2:0] F3_SR     = 3'b101;  // srl or sra
    localparam logic [2:0] F3_OR     = 3'b110;
    localparam logic [2:0] F3_AND    = 3'b111;

    // Branch func3
    localparam logic [2:0] F3_BEQ    = 3'b000;
    localparam logic [2:0] F3_BNE    = 3'b001;
    localparam logic [2:0] F3_BLT    = 3'b100;
    localparam logic [2:0] F3_BGE    = 3'b101;
    localparam logic [2:0] F3_BLTU   = 3'b110;
    localparam logic [2:0] F3_BGEU   = 3'b111;

    // Multiply and divide func3
    localparam logic [2:0] F3_MUL    = 3'b000;
    localparam logic [2:0] F3_MULH   = 3'b001;
    localparam logic [2:0] F3_MULHSU = 3'b010;
    localparam logic [2:0] F3_MULHU  = 3'b011;
    localparam logic [2:0] F3_DIV    = 3'b100;
    localparam logic [2:0] F3_DIVU   = 3'b101;
    localparam logic [2:0] F3_REM    = 3'b110;
    localparam logic [2:0] F3_REMU   = 3'b111;

endpackage

`default_nettype wire

// File: logic/dispatch_decoder.sv
`timescale 1ns/100ps
`default_nettype none

module dispatch_decoder (
    input  wire                  clk,
    input  wire                  reset,
    input  wire                  execute_on,  // Issue strobe
    input  wire  [6:0]           opcode,
    input  wire  exec_pkg::uop_t issue_uop,
    output logic                 add_push,
    output logic                 mul_push,
    output logic                 div_push,
    output exec_pkg::uop_t       routed_uop
);

    exec_pkg::unit_e unit;

    // Pick the target station from the major opcode
    always_comb begin
        case (opcode)
            exec_pkg::OP_MULDIV: begin
                unit = exec_pkg::UNIT_DIV;
            end
            exec_pkg::OP_ALU: begin
                // Multiply shares the register ALU opcode
                if (issue_uop.ctl.muldiv) begin
                    unit = exec_pkg::UNIT_MUL;
                end else begin
                    unit = exec_pkg::UNIT_ADD;
                end
            end
            exec_pkg::OP_ALUI,
            exec_pkg::OP_BRANCH: begin
                unit = exec_pkg::UNIT_ADD;
            end
            default: begin
                unit = exec_pkg::UNIT_ADD;  // Unknown opcodes go to the add unit
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            add_push   <= 1'b0;
            mul_push   <= 1'b0;
            div_push   <= 1'b0;
            routed_uop <= '0;
        end else begin
            add_push <= execute_on && (unit == exec_pkg::UNIT_ADD);  // One push per issue
            mul_push <= execute_on && (unit == exec_pkg::UNIT_MUL);
            div_push <= execute_on && (unit == exec_pkg::UNIT_DIV);
            if (execute_on) begin
                routed_uop <= issue_uop;
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/rs_queue.sv
`timescale 1ns/100ps
`default_nettype none

module rs_queue #(
    parameter int DEPTH = 4
) (
    input  wire                  clk,
    input  wire                  reset,
    input  wire                  push,
    input  wire  exec_pkg::uop_t push_uop,
    input  wire                  pop,
    output exec_pkg::uop_t       head,
    output logic                 not_empty,
    output logic                 full
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    exec_pkg::uop_t   mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    assign not_empty = (count != '0);
    assign full      = (count == CNT_W'(DEPTH));
    assign head      = mem[rd_ptr];

    assign do_pop  = pop && not_empty;
    assign do_push = push && (!full || do_pop);  // A full queue still takes a push on pop

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_uop;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;  // Wrap
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: logic/add_unit.sv
`timescale 1ns/100ps
`default_nettype none

module add_unit (
    input  wire                  clk,
    input  wire                  reset,
    input  wire                  not_empty,
    input  wire  exec_pkg::uop_t head,
    output logic                 pop,
    output exec_pkg::result_t    result
);

    exec_pkg::uop_t op_q;      // Op taken from the queue
    logic           op_valid_q;
    logic [31:0]    alu_value;
    logic           taken;

    assign pop = not_empty;  // Takes one op every cycle

    always_comb begin
        case (op_q.func3)
            exec_pkg::F3_ADD:  alu_value = (op_q.ctl.sub && !op_q.ctl.imm) ?
                                           op_q.operand1 - op_q.operand2 :
                                           op_q.operand1 + op_q.operand2;
            exec_pkg::F3_SLL:  alu_value = op_q.operand1 << op_q.operand2[4:0];
            exec_pkg::F3_SLT:  alu_value = {31'd0, $signed(op_q.operand1) < $signed(op_q.operand2)};
            exec_pkg::F3_SLTU: alu_value = {31'd0, op_q.operand1 < op_q.operand2};
            exec_pkg::F3_XOR:  alu_value = op_q.operand1 ^ op_q.operand2;
            exec_pkg::F3_SR:   alu_value = op_q.ctl.sub ?
                                           32'($signed(op_q.operand1) >>> op_q.operand2[4:0]) :
                                           op_q.operand1 >> op_q.operand2[4:0];
            exec_pkg::F3_OR:   alu_value = op_q.operand1 | op_q.operand2;
            default:           alu_value = op_q.operand1 & op_q.operand2;
        endcase
    end

    // Branch condition, only meaningful with ctl.branch
    always_comb begin
        case (op_q.func3)
            exec_pkg::F3_BEQ:  taken = (op_q.operand1 == op_q.operand2);
            exec_pkg::F3_BNE:  taken = (op_q.operand1 != op_q.operand2);
            exec_pkg::F3_BLT:  taken = ($signed(op_q.operand1) < $signed(op_q.operand2));
            exec_pkg::F3_BGE:  taken = ($signed(op_q.operand1) >= $signed(op_q.operand2));
            exec_pkg::F3_BLTU: taken = (op_q.operand1 < op_q.operand2);
            exec_pkg::F3_BGEU: taken = (op_q.operand1 >= op_q.operand2);
            default:           taken = 1'b0;  // Reserved encodings never branch
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            op_valid_q <= 1'b0;
            result     <= '0;
        end else begin
            op_valid_q <= pop;
            if (pop) begin
                op_q <= head;
            end
            result.valid      <= op_valid_q;
            result.rd_phy_reg <= op_q.rd_phy_reg;
            if (op_q.ctl.branch) begin
                result.value <= taken ? op_q.pc + op_q.label : op_q.pc + 32'd4;
                result.taken <= taken;
            end else begin
                result.value <= alu_value;
                result.taken <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/mul_unit.sv
`timescale 1ns/100ps
`default_nettype none

module mul_unit (
    input  wire                  clk,
    input  wire                  reset,
    input  wire                  not_empty,
    input  wire  exec_pkg::uop_t head,
    output logic                 pop,
    output exec_pkg::result_t    result
);

    // Stage 1 holds operands
    logic               s1_valid;
    logic [31:0]        s1_a;
    logic [31:0]        s1_b;
    logic [2:0]         s1_func3;
    logic [7:0]         s1_rd;
    // Stage 2 holds the full product
    logic               s2_valid;
    logic [63:0]        s2_product;
    logic [2:0]         s2_func3;
    logic [7:0]         s2_rd;

    logic signed [32:0] a_ext;
    logic signed [32:0] b_ext;
    logic signed [63:0] product;

    assign pop = not_empty;  // Fully pipelined so it never stalls

    // Sign extension per operand picks the mulh flavour
    assign a_ext   = {((s1_func3 == exec_pkg::F3_MULH) || (s1_func3 == exec_pkg::F3_MULHSU))
                      && s1_a[31], s1_a};
    assign b_ext   = {(s1_func3 == exec_pkg::F3_MULH) && s1_b[31], s1_b};
    assign product = 64'(a_ext) * 64'(b_ext);

    always_ff @(posedge clk) begin
        if (reset) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
            result   <= '0;
        end else begin
            s1_valid   <= pop;
            s1_a       <= head.operand1;
            s1_b       <= head.operand2;
            s1_func3   <= head.func3;
            s1_rd      <= head.rd_phy_reg;

            s2_valid   <= s1_valid;
            s2_product <= product;
            s2_func3   <= s1_func3;
            s2_rd      <= s1_rd;

            result.valid      <= s2_valid;
            result.rd_phy_reg <= s2_rd;
            result.value      <= (s2_func3 == exec_pkg::F3_MUL) ? s2_product[31:0] :
                                                                  s2_product[63:32];
            result.taken      <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: logic/div_unit.sv
`timescale 1ns/100ps
`default_nettype none

module div_unit (
    input  wire                  clk,
    input  wire                  reset,
    input  wire                  not_empty,
    input  wire  exec_pkg::uop_t head,
    output logic                 pop,
    output exec_pkg::result_t    result
);

    typedef enum logic [1:0] {
        DIV_IDLE,
        DIV_RUN,
        DIV_DONE
    } div_state_e;

    div_state_e  state;
    logic [4:0]  count;        // Iteration index
    logic [31:0] rem_q;        // Partial remainder
    logic [31:0] quo_q;        // Dividend shifting into quotient
    logic [31:0] divisor_q;    // Divisor magnitude
    logic [31:0] dividend_q;   // Original dividend
    logic [7:0]  rd_q;
    logic        is_rem_q;
    logic        neg_quo_q;
    logic        neg_rem_q;
    logic        div_zero_q;
    logic        overflow_q;

    logic        is_signed;
    logic        a_neg;
    logic        b_neg;
    logic [32:0] shifted;
    logic [32:0] trial;
    logic [31:0] quotient;
    logic [31:0] remainder;

    assign pop = (state == DIV_IDLE) && not_empty;

    assign is_signed = (head.func3 == exec_pkg::F3_DIV) || (head.func3 == exec_pkg::F3_REM);
    assign a_neg     = is_signed && head.operand1[31];
    assign b_neg     = is_signed && head.operand2[31];

    // One restoring step
    assign shifted = {rem_q, quo_q[31]};
    assign trial   = shifted - {1'b0, divisor_q};

    assign quotient  = neg_quo_q ? -quo_q : quo_q;
    assign remainder = neg_rem_q ? -rem_q : rem_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            state  <= DIV_IDLE;
            count  <= '0;
            result <= '0;
        end else begin
            result.valid <= 1'b0;
            case (state)
                DIV_IDLE: begin
                    if (pop) begin
                        quo_q      <= a_neg ? -head.operand1 : head.operand1;
                        divisor_q  <= b_neg ? -head.operand2 : head.operand2;
                        rem_q      <= '0;
                        dividend_q <= head.operand1;
                        rd_q       <= head.rd_phy_reg;
                        is_rem_q   <= (head.func3 == exec_pkg::F3_REM) ||
                                      (head.func3 == exec_pkg::F3_REMU);
                        neg_quo_q  <= a_neg ^ b_neg;
                        neg_rem_q  <= a_neg;  // Remainder follows the dividend sign
                        div_zero_q <= (head.operand2 == '0);
                        overflow_q <= is_signed && (head.operand1 == 32'h8000_0000) &&
                                      (head.operand2 == 32'hffff_ffff);
                        count      <= '0;
                        state      <= DIV_RUN;
                    end
                end
                DIV_RUN: begin
                    if (!trial[32]) begin
                        rem_q <= trial[31:0];
                        quo_q <= {quo_q[30:0], 1'b1};
                    end else begin
                        rem_q <= shifted[31:0];
                        quo_q <= {quo_q[30:0], 1'b0};
                    end
                    count <= count + 1'b1;
                    if (count == 5'd31) begin
                        state <= DIV_DONE;
                    end
                end
                DIV_DONE: begin
                    result.valid      <= 1'b1;
                    result.rd_phy_reg <= rd_q;
                    result.taken      <= 1'b0;
                    if (div_zero_q) begin
                        result.value <= is_rem_q ? dividend_q : 32'hffff_ffff;
                    end else if (overflow_q) begin
                        result.value <= is_rem_q ? 32'd0 : dividend_q;
                    end else begin
                        result.value <= is_rem_q ? remainder : quotient;
                    end
                    state <= DIV_IDLE;
                end
                default: begin
                    state <= DIV_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: logic/exec_cluster.sv
`timescale 1ns/100ps
`default_nettype none

module exec_cluster #(
    parameter int ADD_DEPTH = 4,
    parameter int MUL_DEPTH = 4,
    parameter int DIV_DEPTH = 2
) (
    input  wire                  clk,
    input  wire                  reset,
    input  wire                  execute_on,
    input  wire  [6:0]           opcode,
    input  wire  exec_pkg::uop_t issue_uop,
    output exec_pkg::station_full_t station_full,
    output exec_pkg::result_t    add_result,
    output exec_pkg::result_t    mul_result,
    output exec_pkg::result_t    div_result
);

    exec_pkg::uop_t routed_uop;
    logic           add_push;
    logic           mul_push;
    logic           div_push;

    exec_pkg::uop_t add_head;
    exec_pkg::uop_t mul_head;
    exec_pkg::uop_t div_head;
    logic           add_not_empty;
    logic           mul_not_empty;
    logic           div_not_empty;
    logic           add_pop;
    logic           mul_pop;
    logic           div_pop;
    logic           add_full;
    logic           mul_full;
    logic           div_full;

    assign station_full = '{add: add_full, mul: mul_full, div: div_full};

    dispatch_decoder dispatch_decoder_inst (
        .clk        (clk),
        .reset      (reset),
        .execute_on (execute_on),
        .opcode     (opcode),
        .issue_uop  (issue_uop),
        .add_push   (add_push),
        .mul_push   (mul_push),
        .div_push   (div_push),
        .routed_uop (routed_uop)
    );

    rs_queue #(.DEPTH(ADD_DEPTH)) add_queue_inst (
        .clk(clk), .reset(reset), .push(add_push), .push_uop(routed_uop), .pop(add_pop),
        .head(add_head), .not_empty(add_not_empty), .full(add_full)
    );

    rs_queue #(.DEPTH(MUL_DEPTH)) mul_queue_inst (
        .clk(clk), .reset(reset), .push(mul_push), .push_uop(routed_uop), .pop(mul_pop),
        .head(mul_head), .not_empty(mul_not_empty), .full(mul_full)
    );

    rs_queue #(.DEPTH(DIV_DEPTH)) div_queue_inst (
        .clk(clk), .reset(reset), .push(div_push), .push_uop(routed_uop), .pop(div_pop),
        .head(div_head), .not_empty(div_not_empty), .full(div_full)
    );

    add_unit add_unit_inst (
        .clk(clk), .reset(reset), .not_empty(add_not_empty), .head(add_head),
        .pop(add_pop), .result(add_result)
    );

    mul_unit mul_unit_inst (
        .clk(clk), .reset(reset), .not_empty(mul_not_empty), .head(mul_head),
        .pop(mul_pop), .result(mul_result)
    );

    div_unit div_unit_inst (
        .clk(clk), .reset(reset), .not_empty(div_not_empty), .head(div_head),
        .pop(div_pop), .result(div_result)
    );

endmodule

`default_nettype wire

// File: dv/exec_cluster_tb.sv
`timescale 1ns/100ps
`default_nettype none

module exec_cluster_tb;

    localparam int NUM_ISSUES  = 400;
    localparam int CYCLE_LIMIT = NUM_ISSUES * 40 + 200;

    logic                    clk;
    logic                    reset;
    logic                    execute_on;
    logic [6:0]              opcode;
    exec_pkg::uop_t          issue_uop;
    exec_pkg::station_full_t station_full;
    exec_pkg::result_t       add_result;
    exec_pkg::result_t       mul_result;
    exec_pkg::result_t       div_result;

    exec_pkg::result_t add_exp [$];  // Expected results in issue order
    exec_pkg::result_t mul_exp [$];
    exec_pkg::result_t div_exp [$];
    int                done_count [3];
    int                cycle_count = 0;
    bit                div_full_seen = 1'b0;

    exec_cluster #(
        .ADD_DEPTH (4),
        .MUL_DEPTH (4),
        .DIV_DEPTH (2)
    ) exec_cluster_inst (
        .clk          (clk),
        .reset        (reset),
        .execute_on   (execute_on),
        .opcode       (opcode),
        .issue_uop    (issue_uop),
        .station_full (station_full),
        .add_result   (add_result),
        .mul_result   (mul_result),
        .div_result   (div_result)
    );

    always #5 clk = ~clk;

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("TESTS FAILED");
        $fatal(1, "Simulation stopped on first error");
    endtask

    task automatic check_result(input string name, input exec_pkg::result_t exp,
                                input exec_pkg::result_t act);
        if (act !== exp) begin
            $display("ERROR %s expected rd=%0d value=%h taken=%0b actual rd=%0d value=%h taken=%0b",
                     name, exp.rd_phy_reg, exp.value, exp.taken,
                     act.rd_phy_reg, act.value, act.taken);
            stop_with_failure("Result mismatch");
        end
    endtask

    task automatic check_full(input string name, input exec_pkg::station_full_t exp,
                              input exec_pkg::station_full_t act);
        if (act !== exp) begin
            $display("ERROR %s expected %b actual %b", name, exp, act);
            stop_with_failure("Full bits mismatch");
        end
    endtask

    // Operands lean towards the usual corner values
    function automatic logic [31:0] pick_operand();
        logic [2:0] sel;
        sel = 3'($urandom);
        case (sel)
            3'd0:    return 32'h0000_0000;
            3'd1:    return 32'hffff_ffff;
            3'd2:    return 32'h8000_0000;
            3'd3:    return 32'h0000_0001;
            default: return $urandom;
        endcase
    endfunction

    function automatic logic [6:0] unknown_opcode();
        logic [6:0] op;
        op = 7'($urandom);
        while (op == exec_pkg::OP_ALU || op == exec_pkg::OP_ALUI ||
               op == exec_pkg::OP_BRANCH || op == exec_pkg::OP_MULDIV) begin
            op = 7'($urandom);
        end
        return op;
    endfunction

    function automatic logic [31:0] alu_expect(input exec_pkg::uop_t u);
        logic [31:0] a;
        logic [31:0] b;
        logic [4:0]  sh;
        logic [31:0] v;
        a  = u.operand1;
        b  = u.operand2;
        sh = b[4:0];
        case (u.func3)
            3'b000:  v = (u.ctl.sub && !u.ctl.imm) ? a - b : a + b;
            3'b001:  v = a << sh;
            3'b010:  v = {31'd0, $signed(a) < $signed(b)};
            3'b011:  v = {31'd0, a < b};
            3'b100:  v = a ^ b;
            3'b101:  v = u.ctl.sub ? 32'($signed(a) >>> sh) : a >> sh;
            3'b110:  v = a | b;
            default: v = a & b;
        endcase
        return v;
    endfunction

    function automatic logic branch_taken(input exec_pkg::uop_t u);
        logic [31:0] a;
        logic [31:0] b;
        a = u.operand1;
        b = u.operand2;
        case (u.func3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            3'b111:  return a >= b;
            default: return 1'b0;  // 010 and 011 are reserved
        endcase
    endfunction

    function automatic logic [31:0] mul_expect(input exec_pkg::uop_t u);
        logic        a_signed;
        logic        b_signed;
        logic [63:0] ax;
        logic [63:0] bx;
        logic [63:0] p;
        a_signed = (u.func3 == 3'b001) || (u.func3 == 3'b010);
        b_signed = (u.func3 == 3'b001);
        ax = {{32{a_signed & u.operand1[31]}}, u.operand1};
        bx = {{32{b_signed & u.operand2[31]}}, u.operand2};
        p  = ax * bx;  // Product modulo 2^64 holds the right upper half
        return (u.func3 == 3'b000) ? p[31:0] : p[63:32];
    endfunction

    function automatic logic [31:0] div_expect(input exec_pkg::uop_t u);
        logic               is_rem;
        logic               is_signed;
        logic signed [31:0] sa;
        logic signed [31:0] sb;
        logic [31:0]        v;
        is_rem    = u.func3[1];
        is_signed = !u.func3[0];
        sa = u.operand1;
        sb = u.operand2;
        if (u.operand2 == 32'd0) begin
            v = is_rem ? u.operand1 : 32'hffff_ffff;
        end else if (is_signed && u.operand1 == 32'h8000_0000 && u.operand2 == 32'hffff_ffff) begin
            v = is_rem ? 32'd0 : u.operand1;
        end else begin
            case (u.func3)
                3'b100:  v = sa / sb;
                3'b101:  v = u.operand1 / u.operand2;
                3'b110:  v = sa % sb;  // Sign follows the dividend
                default: v = u.operand1 % u.operand2;
            endcase
        end
        return v;
    endfunction

    // Reference routing and result for one issued op
    task automatic model_issue(input logic [6:0] op, input exec_pkg::uop_t u);
        exec_pkg::result_t r;
        r.valid      = 1'b1;
        r.rd_phy_reg = u.rd_phy_reg;
        r.taken      = 1'b0;
        if (op == exec_pkg::OP_MULDIV) begin
            r.value = div_expect(u);
            div_exp.push_back(r);
        end else if (op == exec_pkg::OP_ALU && u.ctl.muldiv) begin
            r.value = mul_expect(u);
            mul_exp.push_back(r);
        end else begin
            if (u.ctl.branch) begin
                r.taken = branch_taken(u);
                r.value = r.taken ? u.pc + u.label : u.pc + 32'd4;
            end else begin
                r.value = alu_expect(u);
            end
            add_exp.push_back(r);
        end
    endtask

    task automatic build_uop(input int cls, output logic [6:0] op, output exec_pkg::uop_t u);
        logic [31:0] r;
        u.operand1   = pick_operand();
        u.operand2   = pick_operand();
        r            = $urandom;
        u.pc         = {r[31:2], 2'b00};
        u.label      = $urandom;
        u.rd_phy_reg = 8'($urandom);
        u.ctl.branch = 1'b0;
        u.ctl.sub    = 1'($urandom);
        u.ctl.muldiv = 1'($urandom);  // Only matters under OP_ALU
        u.ctl.imm    = 1'b0;
        u.ctl.spare  = 3'($urandom);
        u.func3      = 3'($urandom);
        case (cls)
            0: begin
                r = $urandom % 4;
                if (r == 0) begin
                    op           = exec_pkg::OP_ALU;
                    u.ctl.muldiv = 1'b0;
                end else if (r == 1) begin
                    op        = exec_pkg::OP_ALUI;
                    u.ctl.imm = 1'b1;
                end else if (r == 2) begin
                    op           = exec_pkg::OP_BRANCH;
                    u.ctl.branch = 1'b1;
                end else begin
                    op = unknown_opcode();
                end
            end
            1: begin
                op           = exec_pkg::OP_ALU;
                u.ctl.muldiv = 1'b1;
                u.func3      = {1'b0, 2'($urandom)};
            end
            default: begin
                op      = exec_pkg::OP_MULDIV;
                u.func3 = {1'b1, 2'($urandom)};
                r       = $urandom % 8;
                if (r == 0) begin
                    u.operand1 = 32'h8000_0000;  // Signed overflow case
                    u.operand2 = 32'hffff_ffff;
                end else if (r == 1) begin
                    u.operand2 = 32'd0;
                end
            end
        endcase
    endtask

    task automatic take_result(input int cls, input exec_pkg::result_t act);
        exec_pkg::result_t exp;
        string             name;
        int                left;
        case (cls)
            0:       left = add_exp.size();
            1:       left = mul_exp.size();
            default: left = div_exp.size();
        endcase
        if (left == 0) begin
            stop_with_failure($sformatf("Unit %0d reported a result that was never issued", cls));
        end else begin
            case (cls)
                0: begin
                    exp  = add_exp.pop_front();
                    name = $sformatf("add_result %0d", done_count[0]);
                end
                1: begin
                    exp  = mul_exp.pop_front();
                    name = $sformatf("mul_result %0d", done_count[1]);
                end
                default: begin
                    exp  = div_exp.pop_front();
                    name = $sformatf("div_result %0d", done_count[2]);
                end
            endcase
            done_count[cls] = done_count[cls] + 1;
            check_result(name, exp, act);
        end
    endtask

    // Results are sampled away from the active edge
    always @(negedge clk) begin
        if (!reset) begin
            if (station_full.div) begin
                div_full_seen = 1'b1;
            end
            if (add_result.valid) begin
                take_result(0, add_result);
            end
            if (mul_result.valid) begin
                take_result(1, mul_result);
            end
            if (div_result.valid) begin
                take_result(2, div_result);
            end
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            stop_with_failure("Timeout, results still outstanding at the cycle limit");
        end
    end

    initial begin : main_sequence
        int             issued;
        int             pick;
        int             cls;
        logic           blocked;
        logic [1:0]     div_hist;  // Div issues in the last two slots
        logic [6:0]     op;
        exec_pkg::uop_t u;

        void'($urandom(59));
        clk        = 1'b0;
        reset      = 1'b1;
        execute_on = 1'b0;
        opcode     = '0;
        issue_uop  = '0;
        done_count = '{0, 0, 0};

        repeat (16) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        check_full("full_after_reset", '0, station_full);
        repeat (4) @(posedge clk);  // Quiet window, any valid here has no expected entry

        issued   = 0;
        div_hist = 2'b00;
        while (issued < NUM_ISSUES) begin
            @(posedge clk);
            pick = int'($urandom % 16);
            cls  = (pick < 5) ? 0 : (pick < 9) ? 1 : (pick < 12) ? 2 : 3;
            // A full bit lags an issue by two edges, so div waits out that window
            blocked = (cls == 3) ||
                      (cls == 0 && station_full.add) ||
                      (cls == 1 && station_full.mul) ||
                      (cls == 2 && (station_full.div || div_hist != 2'b00));
            if (!blocked) begin
                build_uop(cls, op, u);
                model_issue(op, u);
                execute_on <= 1'b1;
                opcode     <= op;
                issue_uop  <= u;
                issued = issued + 1;
            end else begin
                execute_on <= 1'b0;
            end
            div_hist = {div_hist[0], !blocked && (cls == 2)};
        end
        @(posedge clk);
        execute_on <= 1'b0;

        while (add_exp.size() + mul_exp.size() + div_exp.size() != 0) begin
            @(posedge clk);
        end
        repeat (40) @(posedge clk);  // Catch stray late pulses

        if (div_full_seen) begin
            $display("TESTS PASSED");
            $finish;
        end else begin
            stop_with_failure("Div queue never reported full during the issue bursts");
        end
    end

endmodule

`default_nettype wire

// File: all.f
logic/exec_pkg.sv
logic/dispatch_decoder.sv
logic/rs_queue.sv
logic/add_unit.sv
logic/mul_unit.sv
logic/div_unit.sv
logic/exec_cluster.sv
dv/exec_cluster_tb.sv

// File: run.sh
#!/bin/sh
# Build the execution cluster testbench with Verilator and run it.
# The run passes only when the pass line shows up in the simulator output.
verilator --binary --timing -j 0 -f all.f --top-module exec_cluster_tb -o exec_cluster_sim \
    && ./obj_dir/exec_cluster_sim | tee /dev/stderr | grep -q "TESTS PASSED" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
